//--- include/tcdm_settings.svh
`ifndef TCDM_SETTINGS_SVH
`define TCDM_SETTINGS_SVH

//////////////////////////////////////////////////
// port and bank counts
//////////////////////////////////////////////////

// requestor ports on the network input
`define TCDM_NUM_IN 4
// single-port banks behind the egress layer
`define TCDM_NUM_BANK 8
// data word width
`define TCDM_DATA_W 32
// words per bank, offset width follows from it
`define TCDM_BANK_DEPTH 16

//////////////////////////////////////////////////
// clos shape
//////////////////////////////////////////////////

// ingress nodes, also egress nodes
`define TCDM_CLOS_R 2
// middle nodes
`define TCDM_CLOS_M 2
// banks per egress node
`define TCDM_CLOS_N 4
// width of the priority lfsr state
`define TCDM_LFSR_W 16

`endif

//--- src/tcdmPkg.sv
`default_nettype none

`include "tcdm_settings.svh"

package tcdmPkg;

  // bank index and word offset widths
  localparam int unsigned BankW   = $clog2(`TCDM_NUM_BANK);
  localparam int unsigned OffsetW = $clog2(`TCDM_BANK_DEPTH);

  // request opcode
  typedef enum logic {
    opLoad  = 1'b0,
    opStore = 1'b1
  } tcdmOp_e;

  // request payload, travels unchanged through all three layers
  // middle layer routes on the bank msb, egress on the lower bits
  typedef struct packed {
    tcdmOp_e                 op;
    logic [BankW-1:0]        bank;
    logic [OffsetW-1:0]      offset;
    logic [`TCDM_DATA_W-1:0] wdata;
  } tcdmReq_t;

  // response payload
  // for a store the word is don't-care
  typedef struct packed {
    logic [`TCDM_DATA_W-1:0] rdata;
  } tcdmRsp_t;

endpackage

`default_nettype wire

//--- src/lfsrPrio.sv
`timescale 1ns/1ps
`default_nettype none

`include "tcdm_settings.svh"

module lfsrPrio #(
  // number of priority bits handed to the arbiters
  parameter int unsigned OutW = 2
) (
  input  wire logic            clk_i,
  input  wire logic            rstN_i,
  // step once per cycle in which a bank takes a request
  input  wire logic            en_i,
  output logic [OutW-1:0]      prio_o
);

  localparam int unsigned W = `TCDM_LFSR_W;

  // galois feedback for x^16 + x^14 + x^13 + x^11 + 1, maximal length
  localparam logic [W-1:0] Taps = W'(16'hB400);
  // any nonzero value works as seed
  localparam logic [W-1:0] Seed = W'(16'hACE1);

  logic [W-1:0] state;

  //////////////////////////////////////////////////
  // shift register
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rstN_i) begin
      state <= Seed;
    end else if (en_i) begin
      // shift right, fold the dropped bit back onto the tap positions
      state <= {1'b0, state[W-1:1]} ^ (state[0] ? Taps : '0);
    end
  end

  // low bits feed the middle and egress priorities
  assign prio_o = state[OutW-1:0];

endmodule

`default_nettype wire

//--- src/xbarNode.sv
`timescale 1ns/1ps
`default_nettype none

module xbarNode import tcdmPkg::*; #(
  // NumIn must be a power of 2 for the pointer wrap
  parameter int unsigned NumIn     = 2,
  parameter int unsigned NumOut    = 2,
  // offer every request on every output
  parameter bit          Broadcast = 1'b0,
  // arbiters start at prio_i instead of their local pointer
  parameter bit          ExtPrio   = 1'b0,
  // lowest bank bit used for routing
  parameter int unsigned SelLsb    = 0,
  localparam int unsigned IdxW     = (NumIn > 1) ? $clog2(NumIn) : 1,
  localparam int unsigned SelW     = (NumOut > 1) ? $clog2(NumOut) : 1
) (
  input  wire logic                   clk_i,
  input  wire logic                   rstN_i,
  // upstream side
  input  wire logic     [NumIn-1:0]   req_i,
  input  wire tcdmReq_t [NumIn-1:0]   data_i,
  output logic          [NumIn-1:0]   gnt_o,
  output logic          [NumIn-1:0]   vld_o,
  output tcdmRsp_t      [NumIn-1:0]   rsp_o,
  // arbitration start when ExtPrio is set
  input  wire logic     [IdxW-1:0]    prio_i,
  // downstream side
  output logic          [NumOut-1:0]  req_o,
  output tcdmReq_t      [NumOut-1:0]  data_o,
  input  wire logic     [NumOut-1:0]  gnt_i,
  input  wire tcdmRsp_t [NumOut-1:0]  rsp_i
);

  // destination of each input when routing on the address
  logic [NumIn-1:0][SelW-1:0]   dest;
  // candidate inputs seen by each output arbiter
  logic [NumOut-1:0][NumIn-1:0] cand;
  // winner per output
  logic [NumOut-1:0][IdxW-1:0]  sel;
  // local round robin pointers
  logic [NumOut-1:0][IdxW-1:0]  rrPtr;
  // accepted-request record for response steering
  logic [NumOut-1:0]            rspVld;
  logic [NumOut-1:0][IdxW-1:0]  rspIdx;

  // first set bit of cand, scanning upward from start with wrap
  function automatic logic [IdxW-1:0] pickFirst(input logic [NumIn-1:0] cand,
                                                input logic [IdxW-1:0]  start);
    logic [IdxW-1:0] idx;
    logic [IdxW-1:0] win;
    logic            found;
    win   = start;
    found = 1'b0;
    for (int k = 0; k < NumIn; k++) begin
      idx = start + IdxW'(k);
      if (!found && cand[idx]) begin
        win   = idx;
        found = 1'b1;
      end
    end
    return win;
  endfunction

  //////////////////////////////////////////////////
  // routing and arbitration
  //////////////////////////////////////////////////

  // bank slice picks the output
  always_comb begin
    for (int i = 0; i < NumIn; i++) begin
      dest[i] = data_i[i].bank[SelLsb +: SelW];
    end
  end

  always_comb begin : arbitrate
    logic [NumIn-1:0] taken;
    logic [IdxW-1:0]  start;
    taken = '0;
    for (int o = 0; o < NumOut; o++) begin
      start = ExtPrio ? prio_i : rrPtr[o];
      // an input already picked by a lower output is not offered again
      // so a broadcast request leaves on one output only
      for (int i = 0; i < NumIn; i++) begin
        cand[o][i] = req_i[i] & ~taken[i] & (Broadcast | (dest[i] == SelW'(o)));
      end
      sel[o]    = pickFirst(cand[o], start);
      req_o[o]  = |cand[o];
      data_o[o] = data_i[sel[o]];
      if (req_o[o]) begin
        taken[sel[o]] = 1'b1;
      end
    end
  end

  // grant flows back combinationally from downstream
  always_comb begin
    gnt_o = '0;
    for (int o = 0; o < NumOut; o++) begin
      if (req_o[o] && gnt_i[o]) begin
        gnt_o[sel[o]] = 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////
  // response steering
  //////////////////////////////////////////////////

  // remember who won each output, one cycle of response latency
  always_ff @(posedge clk_i) begin
    if (!rstN_i) begin
      rspVld <= '0;
      rspIdx <= '0;
      // stagger start points so parallel outputs favour different inputs
      for (int o = 0; o < NumOut; o++) begin
        rrPtr[o] <= IdxW'(o);
      end
    end else begin
      for (int o = 0; o < NumOut; o++) begin
        rspVld[o] <= req_o[o] & gnt_i[o];
        rspIdx[o] <= sel[o];
        // winner moves to lowest priority
        if (req_o[o] && gnt_i[o]) begin
          rrPtr[o] <= sel[o] + 1'b1;
        end
      end
    end
  end

  // hand the downstream word back to the recorded input
  always_comb begin
    vld_o = '0;
    rsp_o = '0;
    for (int o = 0; o < NumOut; o++) begin
      if (rspVld[o]) begin
        vld_o[rspIdx[o]] = 1'b1;
        rsp_o[rspIdx[o]] = rsp_i[o];
      end
    end
  end

endmodule

`default_nettype wire

//--- src/closNet.sv
`timescale 1ns/1ps
`default_nettype none

`include "tcdm_settings.svh"

module closNet import tcdmPkg::*; (
  input  wire logic                         clk_i,
  input  wire logic                         rstN_i,
  // requestor side
  input  wire logic     [`TCDM_NUM_IN-1:0]   req_i,
  input  wire tcdmReq_t [`TCDM_NUM_IN-1:0]   reqData_i,
  output logic          [`TCDM_NUM_IN-1:0]   gnt_o,
  output logic          [`TCDM_NUM_IN-1:0]   vld_o,
  output tcdmRsp_t      [`TCDM_NUM_IN-1:0]   rspData_o,
  // bank side
  output logic          [`TCDM_NUM_BANK-1:0] bankReq_o,
  output tcdmReq_t      [`TCDM_NUM_BANK-1:0] bankData_o,
  input  wire logic     [`TCDM_NUM_BANK-1:0] bankGnt_i,
  input  wire tcdmRsp_t [`TCDM_NUM_BANK-1:0] bankRsp_i
);

  localparam int unsigned R         = `TCDM_CLOS_R;
  localparam int unsigned M         = `TCDM_CLOS_M;
  localparam int unsigned N         = `TCDM_CLOS_N;
  localparam int unsigned InPerNode = `TCDM_NUM_IN / R;
  // priority bits for the RxR middle and MxN egress arbiters
  localparam int unsigned MidW      = $clog2(R);
  localparam int unsigned EgrW      = $clog2(M);

  //////////////////////////////////////////////////
  // inter-layer links
  //////////////////////////////////////////////////

  // ingress node r, output m
  logic     [R-1:0][M-1:0] ingReq, ingGnt;
  tcdmReq_t [R-1:0][M-1:0] ingData;
  tcdmRsp_t [R-1:0][M-1:0] ingRsp;
  // middle node m, upstream input r
  logic     [M-1:0][R-1:0] midReqUp, midGntUp;
  tcdmReq_t [M-1:0][R-1:0] midDataUp;
  tcdmRsp_t [M-1:0][R-1:0] midRspUp;
  // middle node m, downstream output r
  logic     [M-1:0][R-1:0] midReqDn, midGntDn;
  tcdmReq_t [M-1:0][R-1:0] midDataDn;
  tcdmRsp_t [M-1:0][R-1:0] midRspDn;
  // egress node r, input m
  logic     [R-1:0][M-1:0] egrReq, egrGnt;
  tcdmReq_t [R-1:0][M-1:0] egrData;
  tcdmRsp_t [R-1:0][M-1:0] egrRsp;

  // random priority source
  logic [MidW+EgrW-1:0] prio;
  logic                 lfsrEn;

  // transpose between layers
  for (genvar m = 0; m < M; m++) begin : genLinkM
    for (genvar r = 0; r < R; r++) begin : genLinkR
      // ingress to middle
      assign midReqUp[m][r]  = ingReq[r][m];
      assign midDataUp[m][r] = ingData[r][m];
      assign ingGnt[r][m]    = midGntUp[m][r];
      assign ingRsp[r][m]    = midRspUp[m][r];
      // middle to egress
      assign egrReq[r][m]    = midReqDn[m][r];
      assign egrData[r][m]   = midDataDn[m][r];
      assign midGntDn[m][r]  = egrGnt[r][m];
      assign midRspDn[m][r]  = egrRsp[r][m];
    end
  end

  //////////////////////////////////////////////////
  // priorities
  //////////////////////////////////////////////////

  // step only when some bank accepts a request
  assign lfsrEn = |(bankReq_o & bankGnt_i);

  lfsrPrio #(
    .OutW ( MidW + EgrW )
  ) u_lfsrPrio (
    .clk_i  ( clk_i  ),
    .rstN_i ( rstN_i ),
    .en_i   ( lfsrEn ),
    .prio_o ( prio   )
  );

  //////////////////////////////////////////////////
  // node layers
  //////////////////////////////////////////////////

  // ingress broadcasts, local round robin
  for (genvar r = 0; r < R; r++) begin : genIngress
    xbarNode #(
      .NumIn     ( InPerNode ),
      .NumOut    ( M         ),
      .Broadcast ( 1'b1      ),
      .ExtPrio   ( 1'b0      ),
      .SelLsb    ( 0         )
    ) u_ingNode (
      .clk_i  ( clk_i                                 ),
      .rstN_i ( rstN_i                                ),
      .req_i  ( req_i[InPerNode*r +: InPerNode]       ),
      .data_i ( reqData_i[InPerNode*r +: InPerNode]   ),
      .gnt_o  ( gnt_o[InPerNode*r +: InPerNode]       ),
      .vld_o  ( vld_o[InPerNode*r +: InPerNode]       ),
      .rsp_o  ( rspData_o[InPerNode*r +: InPerNode]   ),
      .prio_i ( '0                                    ),
      .req_o  ( ingReq[r]                             ),
      .data_o ( ingData[r]                            ),
      .gnt_i  ( ingGnt[r]                             ),
      .rsp_i  ( ingRsp[r]                             )
    );
  end

  // middle routes on the bank msb towards egress node r
  for (genvar m = 0; m < M; m++) begin : genMiddle
    xbarNode #(
      .NumIn     ( R          ),
      .NumOut    ( R          ),
      .Broadcast ( 1'b0       ),
      .ExtPrio   ( 1'b1       ),
      .SelLsb    ( $clog2(N)  )
    ) u_midNode (
      .clk_i  ( clk_i               ),
      .rstN_i ( rstN_i              ),
      .req_i  ( midReqUp[m]         ),
      .data_i ( midDataUp[m]        ),
      .gnt_o  ( midGntUp[m]         ),
      .vld_o  (                     ),
      .rsp_o  ( midRspUp[m]         ),
      .prio_i ( prio[EgrW +: MidW]  ),
      .req_o  ( midReqDn[m]         ),
      .data_o ( midDataDn[m]        ),
      .gnt_i  ( midGntDn[m]         ),
      .rsp_i  ( midRspDn[m]         )
    );
  end

  // egress routes on the low bank bits, output n drives bank N*r+n
  for (genvar r = 0; r < R; r++) begin : genEgress
    xbarNode #(
      .NumIn     ( M    ),
      .NumOut    ( N    ),
      .Broadcast ( 1'b0 ),
      .ExtPrio   ( 1'b1 ),
      .SelLsb    ( 0    )
    ) u_egrNode (
      .clk_i  ( clk_i                   ),
      .rstN_i ( rstN_i                  ),
      .req_i  ( egrReq[r]               ),
      .data_i ( egrData[r]              ),
      .gnt_o  ( egrGnt[r]               ),
      .vld_o  (                         ),
      .rsp_o  ( egrRsp[r]               ),
      .prio_i ( prio[0 +: EgrW]         ),
      .req_o  ( bankReq_o[N*r +: N]     ),
      .data_o ( bankData_o[N*r +: N]    ),
      .gnt_i  ( bankGnt_i[N*r +: N]     ),
      .rsp_i  ( bankRsp_i[N*r +: N]     )
    );
  end

endmodule

`default_nettype wire

//--- src/sramBank.sv
`timescale 1ns/1ps
`default_nettype none

`include "tcdm_settings.svh"

module sramBank import tcdmPkg::*; (
  input  wire logic     clk_i,
  input  wire logic     rstN_i,
  // bank is always ready, every request is taken
  input  wire logic     req_i,
  input  wire tcdmReq_t data_i,
  // response one cycle after the request
  output tcdmRsp_t      rsp_o
);

  // word storage
  logic [`TCDM_DATA_W-1:0] mem [`TCDM_BANK_DEPTH];

  //////////////////////////////////////////////////
  // write port
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (req_i && data_i.op == opStore) begin
      mem[data_i.offset] <= data_i.wdata;
    end
  end

  //////////////////////////////////////////////////
  // read port
  //////////////////////////////////////////////////

  // store keeps the previous word on rsp_o
  always_ff @(posedge clk_i) begin
    if (!rstN_i) begin
      rsp_o <= '0;
    end else if (req_i && data_i.op == opLoad) begin
      rsp_o.rdata <= mem[data_i.offset];
    end
  end

endmodule

`default_nettype wire

//--- src/tcdmTop.sv
`timescale 1ns/1ps
`default_nettype none

`include "tcdm_settings.svh"

module tcdmTop import tcdmPkg::*; (
  input  wire logic                       clk_i,
  input  wire logic                       rstN_i,
  // requestor ports
  input  wire logic     [`TCDM_NUM_IN-1:0] req_i,
  input  wire tcdmReq_t [`TCDM_NUM_IN-1:0] reqData_i,
  output logic          [`TCDM_NUM_IN-1:0] gnt_o,
  output logic          [`TCDM_NUM_IN-1:0] vld_o,
  output tcdmRsp_t      [`TCDM_NUM_IN-1:0] rspData_o
);

  // bank side of the network
  logic     [`TCDM_NUM_BANK-1:0] bankReq;
  tcdmReq_t [`TCDM_NUM_BANK-1:0] bankData;
  tcdmRsp_t [`TCDM_NUM_BANK-1:0] bankRsp;

  // banks never stall, grant tied high
  closNet u_closNet (
    .clk_i      ( clk_i                      ),
    .rstN_i     ( rstN_i                     ),
    .req_i      ( req_i                      ),
    .reqData_i  ( reqData_i                  ),
    .gnt_o      ( gnt_o                      ),
    .vld_o      ( vld_o                      ),
    .rspData_o  ( rspData_o                  ),
    .bankReq_o  ( bankReq                    ),
    .bankData_o ( bankData                   ),
    .bankGnt_i  ( {`TCDM_NUM_BANK{1'b1}}     ),
    .bankRsp_i  ( bankRsp                    )
  );

  // one bank per egress output
  for (genvar b = 0; b < `TCDM_NUM_BANK; b++) begin : genBank
    sramBank u_sramBank (
      .clk_i  ( clk_i       ),
      .rstN_i ( rstN_i      ),
      .req_i  ( bankReq[b]  ),
      .data_i ( bankData[b] ),
      .rsp_o  ( bankRsp[b]  )
    );
  end

endmodule

`default_nettype wire

//--- bench/tcdmTop_properties.sv
`timescale 1ns/1ps
`default_nettype none

`include "tcdm_settings.svh"

module tcdmTopProperties (
  input wire logic                     clk_i,
  input wire logic                     rstN_i,
  input wire logic [`TCDM_NUM_IN-1:0]  req_i,
  input wire logic [`TCDM_NUM_IN-1:0]  gnt_i,
  input wire logic [`TCDM_NUM_IN-1:0]  vld_i
);

  //////////////////////////////////////////////////
  // requestor handshake
  //////////////////////////////////////////////////

  // a grant only answers a live request
  gntNeedsReq: assert property (@(posedge clk_i) disable iff (!rstN_i)
    (gnt_i & ~req_i) == '0)
    else $error("grant without request, req %h gnt %h", req_i, gnt_i);

  for (genvar k = 0; k < `TCDM_NUM_IN; k++) begin : genPort
    // response exactly one cycle after the accepting edge
    rspAfterGnt: assert property (@(posedge clk_i) disable iff (!rstN_i)
      (req_i[k] && gnt_i[k]) |=> vld_i[k])
      else $error("port %0d missed its response", k);

    // no response without a grant the cycle before
    noStrayRsp: assert property (@(posedge clk_i) disable iff (!rstN_i)
      vld_i[k] |-> $past(req_i[k] && gnt_i[k]))
      else $error("port %0d responded without a grant", k);
  end

endmodule

bind tcdmTop tcdmTopProperties u_tcdmTopProperties (
  .clk_i  ( clk_i  ),
  .rstN_i ( rstN_i ),
  .req_i  ( req_i  ),
  .gnt_i  ( gnt_o  ),
  .vld_i  ( vld_o  )
);

`default_nettype wire

//--- bench/tcdmTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "tcdm_settings.svh"

module tcdmTb import tcdmPkg::*; ();

  localparam int unsigned NumIn      = `TCDM_NUM_IN;
  localparam int unsigned NumBank    = `TCDM_NUM_BANK;
  localparam int unsigned Depth      = `TCDM_BANK_DEPTH;
  localparam int unsigned RandCycles = 400;
  localparam int unsigned TimeCycles = 24;
  localparam int unsigned StoreReqs  = 16;
  // upper bound on requests issued over the whole run
  localparam int unsigned MaxReq = 2 * NumBank + 4 + NumIn * TimeCycles + StoreReqs
                                   + NumIn * RandCycles;
  localparam int unsigned TimeoutCycles = 20 * MaxReq + 100;

  logic                   clk = 1'b0;
  logic                   rstN;
  logic     [NumIn-1:0]   req;
  tcdmReq_t [NumIn-1:0]   reqData;
  logic     [NumIn-1:0]   gnt;
  logic     [NumIn-1:0]   vld;
  tcdmRsp_t [NumIn-1:0]   rspData;

  // reference memory, plus which words hold a known value
  logic [`TCDM_DATA_W-1:0] model [NumBank][Depth];
  bit                      known [NumBank][Depth];

  // per-port request waiting for its grant
  logic [NumIn-1:0]        pendReq;
  tcdmReq_t                pendData [NumIn];
  // per-port response due next cycle
  logic [NumIn-1:0]        expVld;
  logic [NumIn-1:0]        expLoad;
  logic [`TCDM_DATA_W-1:0] expWord [NumIn];
  logic [NumIn-1:0]        lastGnt;

  int     errCount;
  int     testErr;
  int     testsRun;
  int     testsFailed;
  int     gntCount;
  int     vldCount;
  int     cycles;
  integer seed;

  always #2 clk = ~clk;

  tcdmTop u_tcdmTop (
    .clk_i     ( clk     ),
    .rstN_i    ( rstN    ),
    .req_i     ( req     ),
    .reqData_i ( reqData ),
    .gnt_o     ( gnt     ),
    .vld_o     ( vld     ),
    .rspData_o ( rspData )
  );

  // hard stop in case a request is never granted
  always @(posedge clk) begin
    cycles++;
    if (cycles > TimeoutCycles) begin
      $display("timeout after %0d cycles, a request was never granted", cycles);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // cycle engine
  //////////////////////////////////////////////////

  task automatic issue(input int k, input tcdmOp_e op, input int bank, input int offset,
                       input logic [`TCDM_DATA_W-1:0] wdata);
    pendReq[k]         = 1'b1;
    pendData[k].op     = op;
    pendData[k].bank   = bank[BankW-1:0];
    pendData[k].offset = offset[OffsetW-1:0];
    pendData[k].wdata  = wdata;
  endtask

  task automatic issueRandom(input int k, input tcdmOp_e op);
    logic [31:0] rnd;
    rnd = $random(seed);
    issue(k, op, int'(rnd[2:0]), int'(rnd[7:4]), $random(seed));
  endtask

  // one clock: check due responses, drive on the falling edge, sample grants
  task automatic runCycle();
    tcdmReq_t r;
    @(negedge clk);
    for (int k = 0; k < NumIn; k++) begin
      if (vld[k]) vldCount++;
      if (expVld[k] && !vld[k]) begin
        $display("no response after grant on port %0d", k);
        errCount++;
      end
      if (!expVld[k] && vld[k]) begin
        $display("response without a grant on port %0d", k);
        errCount++;
      end
      if (expVld[k] && vld[k] && expLoad[k] && rspData[k].rdata !== expWord[k]) begin
        $display("ERR rspData_o port %0d exp %h got %h", k, expWord[k], rspData[k].rdata);
        errCount++;
      end
    end
    // a request stays on the port until its grant
    for (int k = 0; k < NumIn; k++) begin
      req[k]     = pendReq[k];
      reqData[k] = pendData[k];
    end
    // grant is combinational, settled well before the rising edge
    #1;
    lastGnt = gnt;
    expVld  = '0;
    expLoad = '0;
    for (int k = 0; k < NumIn; k++) begin
      if (gnt[k] && !pendReq[k]) begin
        $display("grant without a request on port %0d", k);
        errCount++;
      end
      if (gnt[k] && pendReq[k]) begin
        gntCount++;
        r          = pendData[k];
        expVld[k]  = 1'b1;
        pendReq[k] = 1'b0;
        if (r.op == opLoad) begin
          expLoad[k] = known[r.bank][r.offset];
          expWord[k] = model[r.bank][r.offset];
        end else begin
          model[r.bank][r.offset] = r.wdata;
          known[r.bank][r.offset] = 1'b1;
        end
      end
    end
  endtask

  // run until every request is granted and answered
  task automatic drain();
    while (pendReq != '0 || expVld != '0) begin
      runCycle();
    end
  endtask

  task automatic finishTest(input string name);
    testsRun++;
    if (errCount == testErr) begin
      $display("test %-14s ok", name);
    end else begin
      testsFailed++;
      $display("test %-14s failed, %0d errors", name, errCount - testErr);
    end
    testErr = errCount;
  endtask

  //////////////////////////////////////////////////
  // tests
  //////////////////////////////////////////////////

  task automatic testIdle();
    for (int c = 0; c < 10; c++) begin
      runCycle();
      if (lastGnt != '0) begin
        $display("ERR gnt_o exp %h got %h", {NumIn{1'b0}}, lastGnt);
        errCount++;
      end
      if (vld != '0) begin
        $display("ERR vld_o exp %h got %h", {NumIn{1'b0}}, vld);
        errCount++;
      end
    end
    finishTest("after reset");
  endtask

  task automatic testRoundTrip();
    for (int b = 0; b < NumBank; b++) begin
      issue(0, opStore, b, 3, {8'hd0, 8'(b), 16'h5a03});
      drain();
    end
    for (int b = 0; b < NumBank; b++) begin
      issue(0, opLoad, b, 3, '0);
      drain();
    end
    finishTest("round trip");
  endtask

  task automatic checkOneGrant(input logic [NumIn-1:0] ports);
    if ($countones(lastGnt & ports) != 1) begin
      $display("bank conflict granted %0d requests instead of one",
               $countones(lastGnt & ports));
      errCount++;
    end
  endtask

  task automatic testConflict();
    // ports 0 and 2 sit on different ingress nodes and meet at bank 5
    issue(0, opStore, 5, 7, 32'h0bad_0007);
    issue(2, opStore, 5, 9, 32'h0bad_0009);
    runCycle();
    checkOneGrant(4'b0101);
    drain();
    issue(0, opLoad, 5, 9, '0);
    issue(2, opLoad, 5, 7, '0);
    runCycle();
    checkOneGrant(4'b0101);
    drain();
    finishTest("conflict");
  endtask

  task automatic checkCounts(input int gnt0, input int vld0);
    if (vldCount - vld0 != gntCount - gnt0) begin
      $display("%0d responses seen for %0d grants", vldCount - vld0, gntCount - gnt0);
      errCount++;
    end
  endtask

  task automatic testTiming();
    int gnt0;
    int vld0;
    gnt0 = gntCount;
    vld0 = vldCount;
    // back to back loads on every port
    for (int c = 0; c < TimeCycles; c++) begin
      for (int k = 0; k < NumIn; k++) begin
        if (!pendReq[k]) issueRandom(k, opLoad);
      end
      runCycle();
    end
    drain();
    checkCounts(gnt0, vld0);
    finishTest("timing");
  endtask

  task automatic testRandom();
    logic [31:0] rnd;
    for (int c = 0; c < RandCycles; c++) begin
      for (int k = 0; k < NumIn; k++) begin
        rnd = $random(seed);
        // about three in four idle ports start a request
        if (!pendReq[k] && rnd[1:0] != 2'b00) begin
          issueRandom(k, rnd[2] ? opStore : opLoad);
        end
      end
      runCycle();
    end
    drain();
    finishTest("random");
  endtask

  task automatic testStoreRsp();
    int gnt0;
    int vld0;
    gnt0 = gntCount;
    vld0 = vldCount;
    for (int s = 0; s < StoreReqs; s++) begin
      issueRandom(3, opStore);
      drain();
    end
    checkCounts(gnt0, vld0);
    finishTest("store response");
  endtask

  //////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////

  initial begin
    seed        = 32'h1a90;
    rstN        = 1'b0;
    req         = '0;
    reqData     = '0;
    pendReq     = '0;
    expVld      = '0;
    expLoad     = '0;
    lastGnt     = '0;
    errCount    = 0;
    testErr     = 0;
    testsRun    = 0;
    testsFailed = 0;
    gntCount    = 0;
    vldCount    = 0;
    cycles      = 0;
    for (int k = 0; k < NumIn; k++) begin
      pendData[k] = '0;
      expWord[k]  = '0;
    end
    for (int b = 0; b < NumBank; b++) begin
      for (int o = 0; o < Depth; o++) begin
        known[b][o] = 1'b0;
        model[b][o] = '0;
      end
    end
    // three rising edges under reset
    repeat (3) @(negedge clk);
    rstN = 1'b1;
    testIdle();
    testRoundTrip();
    testConflict();
    testTiming();
    testRandom();
    testStoreRsp();
    $display("tests %0d, failed %0d, errors %0d, grants %0d, responses %0d",
             testsRun, testsFailed, errCount, gntCount, vldCount);
    if (errCount == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- build.f
+incdir+include
src/tcdmPkg.sv
src/lfsrPrio.sv
src/xbarNode.sv
src/closNet.sv
src/sramBank.sv
src/tcdmTop.sv
bench/tcdmTop_properties.sv
bench/tcdmTb.sv

//--- Bender.yml
package:
  name: tcdm

export_include_dirs:
  - include

sources:
  - files:
      - src/tcdmPkg.sv
      - src/lfsrPrio.sv
      - src/xbarNode.sv
      - src/closNet.sv
      - src/sramBank.sv
      - src/tcdmTop.sv
  - target: test
    files:
      - bench/tcdmTop_properties.sv
      - bench/tcdmTb.sv
